// ==== trap_pkg.sv ====
// machine-mode interrupts only: no exception causes, no mtval, one hart, XLEN fixed at 32
package trap_pkg;

    localparam int XLEN        = 32;
    localparam int CSR_ADDR_W  = 12;
    localparam int SYNC_STAGES = 2;    // flops per interrupt line

    typedef logic [XLEN-1:0]       word_t;      // data word or pc
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [2:0]            irq_vec_t;   // {external, software, timer}
    typedef logic [3:0]            cause_t;     // cause code without the interrupt bit

    // positions inside irq_vec_t
    localparam int IRQ_EXT_IDX = 2;
    localparam int IRQ_SW_IDX  = 1;
    localparam int IRQ_TMR_IDX = 0;

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MINSTRET = 12'hB02;

    // interrupt causes; the same numbers are the bit positions in mie and mip
    localparam cause_t CAUSE_MSI = 4'd3;
    localparam cause_t CAUSE_MTI = 4'd7;
    localparam cause_t CAUSE_MEI = 4'd11;

    // mstatus fields kept by the CSR file
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // mtvec[1:0], anything else is treated as direct
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

endpackage

// ==== irq_sampler.sv ====
// lines are level sensitive and async to clk_i; a pulse shorter than one clock can be missed
`timescale 1ns/1ns

module irq_sampler
    import trap_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     irq_external_i,
    input  logic     irq_software_i,
    input  logic     irq_timer_i,
    output irq_vec_t pending_o
);

    irq_vec_t irq_raw;                 // packed, still async
    irq_vec_t sync_q [SYNC_STAGES];    // [0] sees the pins

    always_comb begin
        irq_raw              = '0;
        irq_raw[IRQ_EXT_IDX] = irq_external_i;
        irq_raw[IRQ_SW_IDX]  = irq_software_i;
        irq_raw[IRQ_TMR_IDX] = irq_timer_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= irq_raw;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pending_o = sync_q[SYNC_STAGES-1];    // last stage only

endmodule

// ==== csr_file.sv ====
// only MIE/MPIE in mstatus, mip is read-only, mepc is word aligned, unknown CSRs read as zero
`timescale 1ns/1ns

module csr_file
    import trap_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_waddr_i,
    input  word_t     csr_wdata_i,
    input  csr_addr_t csr_raddr_i,
    output word_t     csr_rdata_o,
    input  irq_vec_t  pending_i,
    input  logic      retire_i,
    input  logic      trap_enter_i,
    input  logic      trap_return_i,
    input  cause_t    trap_cause_i,
    input  word_t     trap_epc_i,
    output logic      mstatus_mie_o,
    output irq_vec_t  mie_o,
    output irq_vec_t  mip_o,
    output word_t     mtvec_o,
    output word_t     mepc_o
);

    logic            mstatus_mie_q;
    logic            mstatus_mpie_q;
    irq_vec_t        mie_q;
    logic [XLEN-1:2] mtvec_base_q;
    logic            mtvec_mode_q;     // bit 1 of the mode reads as zero
    logic [XLEN-1:2] mepc_q;
    logic            mcause_irq_q;
    cause_t          mcause_code_q;
    word_t           minstret_q;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_minstret;

    // irq vector <-> mie/mip layout (bit n = cause n)
    function automatic word_t irq_to_word(irq_vec_t v);
        word_t w;
        w            = '0;
        w[CAUSE_MEI] = v[IRQ_EXT_IDX];
        w[CAUSE_MSI] = v[IRQ_SW_IDX];
        w[CAUSE_MTI] = v[IRQ_TMR_IDX];
        return w;
    endfunction

    function automatic irq_vec_t word_to_irq(word_t w);
        irq_vec_t v;
        v              = '0;
        v[IRQ_EXT_IDX] = w[CAUSE_MEI];
        v[IRQ_SW_IDX]  = w[CAUSE_MSI];
        v[IRQ_TMR_IDX] = w[CAUSE_MTI];
        return v;
    endfunction

    assign wr_mstatus  = csr_we_i && (csr_waddr_i == CSR_MSTATUS);
    assign wr_mie      = csr_we_i && (csr_waddr_i == CSR_MIE);
    assign wr_mtvec    = csr_we_i && (csr_waddr_i == CSR_MTVEC);
    assign wr_mepc     = csr_we_i && (csr_waddr_i == CSR_MEPC);
    assign wr_mcause   = csr_we_i && (csr_waddr_i == CSR_MCAUSE);
    assign wr_minstret = csr_we_i && (csr_waddr_i == CSR_MINSTRET);

    // mstatus: trap and mret beat a software write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end else if (trap_enter_i) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;    // no nesting until software allows it
        end else if (trap_return_i) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (wr_mstatus) begin
            mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
            mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
        end
    end

    // software-only registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_q        <= '0;
            mtvec_base_q <= '0;
            mtvec_mode_q <= 1'b0;
        end else begin
            if (wr_mie) mie_q <= word_to_irq(csr_wdata_i);
            if (wr_mtvec) begin
                mtvec_base_q <= csr_wdata_i[XLEN-1:2];
                mtvec_mode_q <= csr_wdata_i[0];
            end
        end
    end

    // mepc and mcause, trap entry first
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mepc_q        <= '0;
            mcause_irq_q  <= 1'b0;
            mcause_code_q <= '0;
        end else if (trap_enter_i) begin
            mepc_q        <= trap_epc_i[XLEN-1:2];
            mcause_irq_q  <= 1'b1;    // always an interrupt here
            mcause_code_q <= trap_cause_i;
        end else begin
            if (wr_mepc) mepc_q <= csr_wdata_i[XLEN-1:2];
            if (wr_mcause) begin
                mcause_irq_q  <= csr_wdata_i[XLEN-1];
                mcause_code_q <= csr_wdata_i[3:0];
            end
        end
    end

    // write drops the retire of the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            minstret_q <= '0;
        end else if (wr_minstret) begin
            minstret_q <= csr_wdata_i;
        end else if (retire_i) begin
            minstret_q <= minstret_q + word_t'(1);
        end
    end

    always_comb begin
        csr_rdata_o = '0;
        case (csr_raddr_i)
            CSR_MSTATUS: begin
                csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
                csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
            end
            CSR_MIE:      csr_rdata_o = irq_to_word(mie_q);
            CSR_MIP:      csr_rdata_o = irq_to_word(pending_i);
            CSR_MTVEC:    csr_rdata_o = mtvec_o;
            CSR_MEPC:     csr_rdata_o = mepc_o;
            CSR_MCAUSE:   csr_rdata_o = {mcause_irq_q, {(XLEN-5){1'b0}}, mcause_code_q};
            CSR_MINSTRET: csr_rdata_o = minstret_q;
            default:      csr_rdata_o = '0;
        endcase
    end

    assign mstatus_mie_o = mstatus_mie_q;
    assign mie_o         = mie_q;
    assign mip_o         = pending_i;
    assign mtvec_o       = {mtvec_base_q, 1'b0, mtvec_mode_q};
    assign mepc_o        = {mepc_q, 2'b00};

    // the redirect block must never ask for both updates at once
    a_enter_return_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(trap_enter_i && trap_return_i));

endmodule

// ==== irq_arbiter.sv ====
// fixed priority external > software > timer; cause is don't-care while irq_take_o is low
`timescale 1ns/1ns

module irq_arbiter
    import trap_pkg::*;
(
    input  logic     mstatus_mie_i,
    input  irq_vec_t mie_i,
    input  irq_vec_t mip_i,
    output logic     irq_take_o,
    output cause_t   irq_cause_o
);

    irq_vec_t enabled;    // pending and locally enabled

    assign enabled = mip_i & mie_i;

    // global enable only gates the request
    assign irq_take_o = mstatus_mie_i && (|enabled);

    always_comb begin
        if (enabled[IRQ_EXT_IDX]) begin
            irq_cause_o = CAUSE_MEI;
        end else if (enabled[IRQ_SW_IDX]) begin
            irq_cause_o = CAUSE_MSI;
        end else begin
            irq_cause_o = CAUSE_MTI;    // timer, or nothing at all
        end
    end

endmodule

// ==== trap_redirect.sv ====
// traps only at a retire boundary; a retire or mret in the redirect cycle is not acted on
`timescale 1ns/1ns

module trap_redirect
    import trap_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   retire_i,
    input  word_t  retire_pc_i,
    input  logic   mret_i,
    input  logic   irq_take_i,
    input  cause_t irq_cause_i,
    input  word_t  mtvec_i,
    input  word_t  mepc_i,
    output logic   trap_enter_o,
    output logic   trap_return_o,
    output cause_t trap_cause_o,
    output word_t  trap_epc_o,
    output logic   redirect_o,
    output word_t  redirect_pc_o
);

    logic  take_trap;
    logic  take_mret;
    word_t mtvec_base;
    word_t trap_target;

    // while redirect_o is high the CSR update has not landed yet and MIE still reads set
    assign take_trap = retire_i && irq_take_i && !redirect_o;
    assign take_mret = mret_i && !take_trap && !redirect_o;    // trap wins

    assign mtvec_base = {mtvec_i[XLEN-1:2], 2'b00};

    always_comb begin
        if (mtvec_i[1:0] == MTVEC_MODE_VECTORED) begin
            trap_target = mtvec_base + word_t'({irq_cause_i, 2'b00});    // base + 4*cause
        end else begin
            trap_target = mtvec_base;
        end
    end

    // strobes, all one cycle wide
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            redirect_o    <= 1'b0;
            trap_enter_o  <= 1'b0;
            trap_return_o <= 1'b0;
        end else begin
            redirect_o    <= take_trap || take_mret;
            trap_enter_o  <= take_trap;
            trap_return_o <= take_mret;
        end
    end

    // payload, only meaningful next to a strobe
    always_ff @(posedge clk_i) begin
        if (take_trap) begin
            trap_cause_o  <= irq_cause_i;
            trap_epc_o    <= retire_pc_i + word_t'(4);    // resume after the retired one
            redirect_pc_o <= trap_target;
        end else if (take_mret) begin
            redirect_pc_o <= mepc_i;
        end
    end

    // the flush cycle itself never starts another redirect
    a_redirect_single: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_o |=> !redirect_o);

    a_enter_redirects: assert property (@(posedge clk_i) disable iff (rst_i)
        trap_enter_o |-> redirect_o);

endmodule

// ==== trap_unit_top.sv ====
// interrupt path only; the pipeline supplies retire, mret and CSR accesses and follows redirect_o
`timescale 1ns/1ns

module trap_unit_top
    import trap_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      irq_external_i,
    input  logic      irq_software_i,
    input  logic      irq_timer_i,
    input  logic      retire_i,
    input  word_t     retire_pc_i,
    input  logic      mret_i,
    input  logic      csr_we_i,
    input  csr_addr_t csr_waddr_i,
    input  word_t     csr_wdata_i,
    input  csr_addr_t csr_raddr_i,
    output word_t     csr_rdata_o,
    output logic      redirect_o,
    output word_t     redirect_pc_o
);

    irq_vec_t irq_pending;    // sampler to CSR file

    // CSR file to arbiter and redirect
    logic     mstatus_mie;
    irq_vec_t mie;
    irq_vec_t mip;
    word_t    mtvec;
    word_t    mepc;

    // arbiter to redirect
    logic     irq_take;
    cause_t   irq_cause;

    // redirect back to CSR file
    logic     trap_enter;
    logic     trap_return;
    cause_t   trap_cause;
    word_t    trap_epc;

    irq_sampler u_irq_sampler (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .irq_external_i (irq_external_i),
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .pending_o      (irq_pending)
    );

    csr_file u_csr_file (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_we_i      (csr_we_i),
        .csr_waddr_i   (csr_waddr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_raddr_i   (csr_raddr_i),
        .csr_rdata_o   (csr_rdata_o),
        .pending_i     (irq_pending),
        .retire_i      (retire_i),      // minstret
        .trap_enter_i  (trap_enter),
        .trap_return_i (trap_return),
        .trap_cause_i  (trap_cause),
        .trap_epc_i    (trap_epc),
        .mstatus_mie_o (mstatus_mie),
        .mie_o         (mie),
        .mip_o         (mip),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    irq_arbiter u_irq_arbiter (
        .mstatus_mie_i (mstatus_mie),
        .mie_i         (mie),
        .mip_i         (mip),
        .irq_take_o    (irq_take),
        .irq_cause_o   (irq_cause)
    );

    trap_redirect u_trap_redirect (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .retire_i      (retire_i),
        .retire_pc_i   (retire_pc_i),
        .mret_i        (mret_i),
        .irq_take_i    (irq_take),
        .irq_cause_i   (irq_cause),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .trap_enter_o  (trap_enter),
        .trap_return_o (trap_return),
        .trap_cause_o  (trap_cause),
        .trap_epc_o    (trap_epc),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// ==== tb_trap_unit.sv ====
// self-checking with a fixed seed; assumes the 2-flop irq sync and a redirect one cycle after the boundary
`timescale 1ns/1ns

module tb_trap_unit
    import trap_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int N_CSR   = 8;
    localparam int N_MIP   = 6;
    localparam int N_MASK  = 16;    // retires per masking case
    localparam int N_TRAP  = 6;     // 2 modes x 3 lines
    localparam int N_PRIO  = 16;
    localparam int N_RET   = 4;
    localparam int MAX_RUN = 24;    // longest retire run for minstret
    // a loop pass stays under 40 cycles, a retire takes 2
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200
        + 40 * (N_CSR + N_MIP + N_TRAP + N_PRIO + N_RET)
        + 2 * (2 * N_MASK + 2 * MAX_RUN);

    logic      clk_i, rst_i;
    logic      irq_external_i, irq_software_i, irq_timer_i;
    logic      retire_i, mret_i, csr_we_i;
    word_t     retire_pc_i, csr_wdata_i, csr_rdata_o, redirect_pc_o;
    csr_addr_t csr_waddr_i, csr_raddr_i;
    logic      redirect_o;

    logic  chk_arm;         // expectation for the cycle after the boundary
    logic  chk_redirect;
    word_t chk_pc;
    int    errors, checks, tests_run, tests_failed;

    trap_unit_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // external, then software, then timer; en is {ext, sw, tmr}
    function automatic logic [3:0] highest_cause(irq_vec_t en);
        if (en[2]) return 4'd11;
        if (en[1]) return 4'd3;
        return 4'd7;
    endfunction

    function automatic word_t expected_target(word_t mtvec, irq_vec_t en);
        word_t base;
        base = {mtvec[31:2], 2'b00};
        if (mtvec[1:0] == 2'b01) return base + 32'(highest_cause(en)) * 4;
        return base;
    endfunction

    // bit n of mie/mip is cause n
    function automatic word_t irq_word(irq_vec_t l);
        return {20'h0, l[2], 3'b000, l[0], 3'b000, l[1], 3'b000};
    endfunction

    task automatic set_lines(irq_vec_t l);
        @(posedge clk_i);
        irq_external_i <= l[2];
        irq_software_i <= l[1];
        irq_timer_i    <= l[0];
    endtask

    task automatic csr_write(csr_addr_t addr, word_t data);
        @(posedge clk_i);
        csr_we_i    <= 1'b1;
        csr_waddr_i <= addr;
        csr_wdata_i <= data;
        @(posedge clk_i);
        csr_we_i    <= 1'b0;
    endtask

    task automatic csr_check(csr_addr_t addr, word_t exp, string name);
        @(posedge clk_i);
        csr_raddr_i <= addr;
        @(negedge clk_i);    // combinational read settled
        checks++;
        if (csr_rdata_o !== exp) begin
            errors++;
            $display("Fail csr_rdata_o (%s) exp %h got %h", name, exp, csr_rdata_o);
        end
    endtask

    task automatic retire_one(word_t pc, logic exp_redir, word_t exp_pc);
        @(posedge clk_i);
        retire_i     <= 1'b1;
        retire_pc_i  <= pc;
        chk_arm      <= 1'b1;
        chk_redirect <= exp_redir;
        chk_pc       <= exp_pc;
        @(posedge clk_i);
        retire_i <= 1'b0;
        chk_arm  <= 1'b0;
    endtask

    task automatic mret_one(word_t exp_pc);
        @(posedge clk_i);
        mret_i       <= 1'b1;
        chk_arm      <= 1'b1;
        chk_redirect <= 1'b1;
        chk_pc       <= exp_pc;
        @(posedge clk_i);
        mret_i  <= 1'b0;
        chk_arm <= 1'b0;
    endtask

    // single trap with global MIE set, all lines enabled unless en says otherwise
    task automatic trap_once(irq_vec_t l, irq_vec_t en, word_t tvec, word_t pc);
        set_lines(l);
        csr_write(CSR_MIE, irq_word(en));
        csr_write(CSR_MTVEC, tvec);
        csr_write(CSR_MSTATUS, 32'h8);
        retire_one(pc, 1'b1, expected_target(tvec, l & en));
    endtask

    task automatic report_test(string name, int errs_before);
        repeat (2) @(posedge clk_i);    // let the last compare land
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin : compare
        logic  arm_q;
        logic  redir_q;
        word_t pc_q;
        forever begin
            @(posedge clk_i);
            arm_q   = chk_arm;
            redir_q = chk_redirect;
            pc_q    = chk_pc;
            @(negedge clk_i);
            if (arm_q && !rst_i) begin
                checks++;
                if (redirect_o !== redir_q) begin
                    errors++;
                    $display("Fail redirect_o exp %h got %h", redir_q, redirect_o);
                end else if (redir_q && redirect_pc_o !== pc_q) begin
                    errors++;
                    $display("Fail redirect_pc_o exp %h got %h", pc_q, redirect_pc_o);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        int       e0, n;
        word_t    w, tvec, pc, ret_pc;
        irq_vec_t l, en, prev;
        void'($urandom(32'h8349));
        {errors, checks, tests_run, tests_failed} = '0;
        {chk_arm, chk_redirect, chk_pc} = '0;
        {irq_external_i, irq_software_i, irq_timer_i, retire_i, mret_i, csr_we_i} = '0;
        {retire_pc_i, csr_wdata_i, csr_waddr_i, csr_raddr_i} = '0;
        rst_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        e0 = errors;    // csr read/write and mip latency
        for (int i = 0; i < N_CSR; i++) begin
            w = $urandom();
            csr_write(CSR_MTVEC, w);
            csr_check(CSR_MTVEC, w & 32'hFFFF_FFFD, "mtvec");
            csr_write(CSR_MIE, w);
            csr_check(CSR_MIE, w & 32'h0000_0888, "mie");
            csr_write(CSR_MSTATUS, w);
            csr_check(CSR_MSTATUS, w & 32'h0000_0088, "mstatus");
            csr_write(CSR_MEPC, w);
            csr_check(CSR_MEPC, w & 32'hFFFF_FFFC, "mepc");
        end
        csr_write(CSR_MSTATUS, 32'h0);
        prev = '0;
        for (int i = 0; i < N_MIP; i++) begin
            l = irq_vec_t'($urandom());
            if (l == prev) l = ~prev;
            set_lines(l);
            csr_check(CSR_MIP, irq_word(prev), "mip one cycle in");
            csr_check(CSR_MIP, irq_word(l), "mip");
            csr_write(CSR_MIP, $urandom());    // read-only
            csr_check(CSR_MIP, irq_word(l), "mip after write");
            prev = l;
        end
        set_lines('0);
        report_test("csr read/write", e0);

        e0 = errors;    // MIE clear, then mie bit clear
        l = irq_vec_t'($urandom_range(7, 1));
        set_lines(l);
        csr_write(CSR_MIE, 32'h888);
        for (int i = 0; i < N_MASK; i++) retire_one($urandom() & 32'hFFFF_FFFC, 1'b0, '0);
        csr_write(CSR_MIE, irq_word(~l));
        csr_write(CSR_MSTATUS, 32'h8);
        for (int i = 0; i < N_MASK; i++) retire_one($urandom() & 32'hFFFF_FFFC, 1'b0, '0);
        csr_write(CSR_MSTATUS, 32'h0);
        set_lines('0);
        report_test("masking", e0);

        e0 = errors;
        for (int i = 0; i < N_TRAP; i++) begin
            l    = irq_vec_t'(3'b001 << (i % 3));
            tvec = ($urandom() & 32'hFFFF_FFFC) | word_t'(i / 3);    // direct, then vectored
            pc   = $urandom() & 32'hFFFF_FFFC;
            trap_once(l, 3'b111, tvec, pc);
            csr_check(CSR_MEPC, pc + 4, "mepc");
            csr_check(CSR_MCAUSE, {1'b1, 27'h0, highest_cause(l)}, "mcause");
            csr_check(CSR_MSTATUS, 32'h80, "mstatus");
            set_lines('0);
        end
        report_test("trap entry", e0);

        e0 = errors;
        for (int i = 0; i < N_PRIO; i++) begin
            l  = irq_vec_t'($urandom_range(7, 1));
            en = irq_vec_t'($urandom_range(7, 1));
            if ((l & en) == '0) en = en | l;
            tvec = ($urandom() & 32'hFFFF_FFFC) | word_t'($urandom_range(1, 0));
            trap_once(l, en, tvec, $urandom() & 32'hFFFF_FFFC);
            csr_check(CSR_MCAUSE, {1'b1, 27'h0, highest_cause(l & en)}, "mcause");
            set_lines('0);
        end
        report_test("priority", e0);

        e0 = errors;
        for (int i = 0; i < N_RET; i++) begin
            l    = irq_vec_t'(3'b001 << $urandom_range(2, 0));
            tvec = ($urandom() & 32'hFFFF_FFFC) | word_t'(i % 2);
            pc   = $urandom() & 32'hFFFF_FFFC;
            trap_once(l, 3'b111, tvec, pc);
            set_lines('0);
            ret_pc = pc + 4;
            if (i % 2 == 1) begin    // handler moved mepc
                ret_pc = $urandom() & 32'hFFFF_FFFC;
                csr_write(CSR_MEPC, ret_pc);
            end
            repeat (2) @(posedge clk_i);    // line low reaches mip before MIE is back
            mret_one(ret_pc);
            csr_check(CSR_MSTATUS, 32'h88, "mstatus");
            csr_write(CSR_MSTATUS, 32'h0);
        end
        report_test("mret return", e0);

        e0 = errors;
        n = $urandom_range(MAX_RUN, 4);
        csr_write(CSR_MINSTRET, 32'h0);
        repeat (n) retire_one($urandom() & 32'hFFFF_FFFC, 1'b0, '0);
        csr_check(CSR_MINSTRET, word_t'(n), "minstret");
        w = $urandom();
        n = $urandom_range(MAX_RUN, 4);
        csr_write(CSR_MINSTRET, w);
        repeat (n) retire_one($urandom() & 32'hFFFF_FFFC, 1'b0, '0);
        csr_check(CSR_MINSTRET, w + word_t'(n), "minstret");
        report_test("retire count", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
trap_pkg.sv
irq_sampler.sv
csr_file.sv
irq_arbiter.sv
trap_redirect.sv
trap_unit_top.sv
tb_trap_unit.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  - trap_pkg.sv
  - irq_sampler.sv
  - csr_file.sv
  - irq_arbiter.sv
  - trap_redirect.sv
  - trap_unit_top.sv
  - target: simulation
    files:
      - tb_trap_unit.sv
